// ==== gpioSys.f ====
hw/usiBusPkg.sv
hw/gpioPkg.sv
hw/usiBusHub.sv
hw/gpioCsr.sv
hw/gpioBlock.sv
hw/pwmBlock.sv
hw/gpioSys.sv
test/gpioSysTb.sv

// ==== test/gpioSysTb.sv ====
// GPIO subsystem testbench
`timescale 1ns/100ps
`default_nettype none

module gpioSysTb;

	// Clock period in ns
	localparam int clkPeriod = 4;
	// Cycle budget of each test in run order
	localparam int testCycles = 20 + 100 + 50 + 60 + 40;
	// Block number with nothing behind it
	localparam usiBusPkg::blockAdrs unmappedId = 8'h03;

	logic iSCLK;
	logic rst;
	usiBusPkg::usiData adrs;
	usiBusPkg::usiData wd;
	logic we;
	logic re;
	usiBusPkg::usiData rd;
	gpioPkg::gpioVec gpioIn;
	gpioPkg::gpioVec gpioOut;
	gpioPkg::gpioVec gpioDir;

	integer seed;
	int errCount;
	int checkCount;
	int testErrStart;
	// Last values written to the GPIO and PWM registers
	gpioPkg::gpioVec outShadow;
	gpioPkg::gpioVec dirShadow;
	int periodShadow;

	gpioSys uut
	(
		.iSCLK(iSCLK),
		.rst(rst),
		.adrs(adrs),
		.wd(wd),
		.we(we),
		.re(re),
		.rd(rd),
		.gpioIn(gpioIn),
		.gpioOut(gpioOut),
		.gpioDir(gpioDir)
	);

	always #(clkPeriod / 2) iSCLK = ~iSCLK;

	// rd only moves on the edge that completes a read
	assert property (@(posedge iSCLK) disable iff (rst) !$past(re, 2) |-> $stable(rd))
	else
	begin
		errCount++;
		$display("rd changed at %0t ns with no read completing", $time);
	end

	// --------------------
	// Helpers
	// --------------------
	// Bus address from block number and CSR offset
	function automatic usiBusPkg::usiData blockAddress(input usiBusPkg::blockAdrs blk,
		input usiBusPkg::csrAdrs ofs);
		usiBusPkg::usiData a;
		a = '0;
		a[15:0] = {blk, ofs};
		return a;
	endfunction

	task automatic expectEqual(input string name, input usiBusPkg::usiData expected,
		input usiBusPkg::usiData actual);
		checkCount++;
		assert (actual === expected)
		else
		begin
			errCount++;
			$display("Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	// All bus tasks start and end 1 ns after a rising edge
	task automatic busWrite(input usiBusPkg::usiData a, input usiBusPkg::usiData d);
		adrs = a;
		wd = d;
		we = 1'b1;
		@(posedge iSCLK);
		#1;
		we = 1'b0;
	endtask

	// Data sampled two edges after the request edge
	task automatic busRead(input usiBusPkg::usiData a, output usiBusPkg::usiData d);
		adrs = a;
		re = 1'b1;
		@(posedge iSCLK);
		#1;
		re = 1'b0;
		@(posedge iSCLK);
		@(posedge iSCLK);
		#1;
		d = rd;
	endtask

	// Two requests on consecutive edges with each word taken as it lands on rd
	task automatic readPair(input usiBusPkg::usiData a, input usiBusPkg::usiData b,
		output usiBusPkg::usiData da, output usiBusPkg::usiData db);
		adrs = a;
		re = 1'b1;
		@(posedge iSCLK);
		#1;
		adrs = b;
		@(posedge iSCLK);
		#1;
		re = 1'b0;
		da = rd;
		@(posedge iSCLK);
		#1;
		db = rd;
	endtask

	task automatic startTest();
		testErrStart = errCount;
	endtask

	task automatic finishTest(input string name);
		$display("Test %s: %s", name, (errCount == testErrStart) ? "passed" : "failed");
	endtask

	// --------------------
	// Tests
	// --------------------
	task automatic afterReset();
		usiBusPkg::usiData d;
		startTest();
		expectEqual("gpioOut", '0, gpioOut);
		expectEqual("gpioDir", '0, gpioDir);
		expectEqual("rd", '0, rd);
		busRead(blockAddress(usiBusPkg::gpioBlockId, gpioPkg::gpioOutOfs), d);
		expectEqual("rd out reg", '0, d);
		busRead(blockAddress(usiBusPkg::gpioBlockId, gpioPkg::gpioDirOfs), d);
		expectEqual("rd dir reg", '0, d);
		busRead(blockAddress(usiBusPkg::gpioBlockId, gpioPkg::gpioAltOfs), d);
		expectEqual("rd alt reg", '0, d);
		busRead(blockAddress(usiBusPkg::gpioBlockId, gpioPkg::gpioInOfs), d);
		expectEqual("rd in reg", '0, d);
		finishTest("reset");
	endtask

	task automatic registerAccess();
		gpioPkg::gpioVec outV;
		gpioPkg::gpioVec dirV;
		gpioPkg::gpioVec altV;
		usiBusPkg::usiData d;
		startTest();
		for (int i = 0; i < 6; i++)
		begin
			outV = $random(seed);
			dirV = $random(seed);
			altV = $random(seed);
			// Alt mode off so gpioOut shows the output register
			busWrite(blockAddress(usiBusPkg::gpioBlockId, gpioPkg::gpioAltOfs), '0);
			busWrite(blockAddress(usiBusPkg::gpioBlockId, gpioPkg::gpioOutOfs), outV);
			// Pin mux register still holds the old value
			expectEqual("gpioOut", outShadow, gpioOut);
			@(posedge iSCLK);
			#1;
			expectEqual("gpioOut", outV, gpioOut);
			busWrite(blockAddress(usiBusPkg::gpioBlockId, gpioPkg::gpioDirOfs), dirV);
			expectEqual("gpioDir", dirV, gpioDir);
			busWrite(blockAddress(usiBusPkg::gpioBlockId, gpioPkg::gpioAltOfs), altV);
			outShadow = outV;
			dirShadow = dirV;
			busRead(blockAddress(usiBusPkg::gpioBlockId, gpioPkg::gpioOutOfs), d);
			expectEqual("rd out reg", outV, d);
			busRead(blockAddress(usiBusPkg::gpioBlockId, gpioPkg::gpioDirOfs), d);
			expectEqual("rd dir reg", dirV, d);
			busRead(blockAddress(usiBusPkg::gpioBlockId, gpioPkg::gpioAltOfs), d);
			expectEqual("rd alt reg", altV, d);
		end
		finishTest("register access");
	endtask

	task automatic inputReadback();
		gpioPkg::gpioVec inV;
		usiBusPkg::usiData d;
		startTest();
		for (int i = 0; i < 8; i++)
		begin
			inV = $random(seed);
			gpioIn = inV;
			// Two cycles through the synchronizer
			@(posedge iSCLK);
			#1;
			@(posedge iSCLK);
			#1;
			busRead(blockAddress(usiBusPkg::gpioBlockId, gpioPkg::gpioInOfs), d);
			expectEqual("rd in reg", inV, d);
		end
		finishTest("input readback");
	endtask

	task automatic alternateMode();
		int duty [gpioPkg::gpioWidth];
		int highCount [gpioPkg::gpioWidth];
		int expected;
		gpioPkg::gpioVec outV;
		gpioPkg::gpioVec altV;
		startTest();
		busWrite(blockAddress(usiBusPkg::pwmBlockId, gpioPkg::pwmCtrlOfs), '0);
		periodShadow = 2 + ($unsigned($random(seed)) % 8);
		busWrite(blockAddress(usiBusPkg::pwmBlockId, gpioPkg::pwmPeriodOfs), periodShadow);
		// Some duties run past the period to cover the saturated case
		for (int ch = 0; ch < gpioPkg::gpioWidth; ch++)
		begin
			duty[ch] = $unsigned($random(seed)) % (periodShadow + 3);
			highCount[ch] = 0;
			busWrite(blockAddress(usiBusPkg::pwmBlockId, gpioPkg::pwmDutyBase + 4 * ch),
				duty[ch]);
		end
		outV = $random(seed);
		altV = $random(seed);
		altV[0] = 1'b1;
		outShadow = outV;
		busWrite(blockAddress(usiBusPkg::gpioBlockId, gpioPkg::gpioOutOfs), outV);
		busWrite(blockAddress(usiBusPkg::gpioBlockId, gpioPkg::gpioAltOfs), altV);
		busWrite(blockAddress(usiBusPkg::pwmBlockId, gpioPkg::pwmCtrlOfs), 1);
		// Let the counter start and the output pipeline fill
		repeat (6) @(posedge iSCLK);
		#1;
		// One full period window
		for (int cyc = 0; cyc <= periodShadow; cyc++)
		begin
			expectEqual("gpioOut plain pins", outV & ~altV, gpioOut & ~altV);
			for (int ch = 0; ch < gpioPkg::gpioWidth; ch++)
				highCount[ch] += gpioOut[ch];
			@(posedge iSCLK);
			#1;
		end
		for (int ch = 0; ch < gpioPkg::gpioWidth; ch++)
		begin
			if (altV[ch])
			begin
				expected = (duty[ch] < periodShadow + 1) ? duty[ch] : periodShadow + 1;
				expectEqual($sformatf("gpioOut[%0d] high cycles", ch), expected,
					highCount[ch]);
			end
		end
		finishTest("alternate mode");
	endtask

	task automatic blockDecode();
		usiBusPkg::usiData d;
		usiBusPkg::usiData d2;
		startTest();
		// Stray writes to unmapped blocks
		busWrite(blockAddress(unmappedId, gpioPkg::gpioOutOfs), $random(seed));
		busWrite(blockAddress(8'h00, gpioPkg::gpioDirOfs), $random(seed));
		expectEqual("gpioDir", dirShadow, gpioDir);
		busRead(blockAddress(usiBusPkg::gpioBlockId, gpioPkg::gpioOutOfs), d);
		expectEqual("rd out reg", outShadow, d);
		busRead(blockAddress(usiBusPkg::gpioBlockId, gpioPkg::gpioDirOfs), d);
		expectEqual("rd dir reg", dirShadow, d);
		// rd is non zero here, so the unmapped read must clear it
		busRead(blockAddress(unmappedId, gpioPkg::gpioOutOfs), d);
		expectEqual("rd unmapped", '0, d);
		readPair(blockAddress(usiBusPkg::gpioBlockId, gpioPkg::gpioOutOfs),
			blockAddress(usiBusPkg::pwmBlockId, gpioPkg::pwmPeriodOfs), d, d2);
		expectEqual("rd out reg, first of pair", outShadow, d);
		expectEqual("rd period, second of pair", periodShadow, d2);
		readPair(blockAddress(unmappedId, gpioPkg::gpioDirOfs),
			blockAddress(usiBusPkg::gpioBlockId, gpioPkg::gpioDirOfs), d, d2);
		expectEqual("rd unmapped, first of pair", '0, d);
		expectEqual("rd dir reg, second of pair", dirShadow, d2);
		finishTest("block decode");
	endtask

	// --------------------
	// Main sequence
	// --------------------
	initial
	begin
		iSCLK = 1'b0;
		rst = 1'b1;
		adrs = '0;
		wd = '0;
		we = 1'b0;
		re = 1'b0;
		gpioIn = '0;
		seed = 32'h22c5;
		errCount = 0;
		checkCount = 0;
		testErrStart = 0;
		outShadow = '0;
		dirShadow = '0;
		periodShadow = 0;
		repeat (4) @(posedge iSCLK);
		#1;
		rst = 1'b0;
		afterReset();
		registerAccess();
		inputReadback();
		alternateMode();
		blockDecode();
		$display("Checks run: %0d, errors: %0d", checkCount, errCount);
		if (errCount == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	// Watchdog at twice the summed budget
	initial
	begin
		#(testCycles * 2 * clkPeriod);
		$display("Run timed out after %0d cycles", testCycles * 2);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hw/gpioSys.sv ====
// GPIO subsystem top
`timescale 1ns/100ps
`default_nettype none

module gpioSys
(
	input  logic iSCLK,
	input  logic rst,
	input  usiBusPkg::usiData adrs,
	input  usiBusPkg::usiData wd,
	input  logic we,
	input  logic re,
	output usiBusPkg::usiData rd,
	input  gpioPkg::gpioVec gpioIn,
	output gpioPkg::gpioVec gpioOut,
	output gpioPkg::gpioVec gpioDir
);

	// Block selects from the hub
	logic gpioSel;
	logic pwmSel;
	// Registered block read words
	usiBusPkg::usiData gpioRd;
	usiBusPkg::usiData pwmRd;
	// PWM channels to GPIO alternate inputs
	gpioPkg::gpioVec pwmOut;

	// --------------------
	// Bus hub
	// --------------------
	usiBusHub hub
	(
		.iSCLK(iSCLK),
		.rst(rst),
		.adrs(adrs),
		.re(re),
		.gpioRd(gpioRd),
		.pwmRd(pwmRd),
		.gpioSel(gpioSel),
		.pwmSel(pwmSel),
		.rd(rd)
	);

	// --------------------
	// Blocks
	// --------------------
	gpioBlock gpio
	(
		.iSCLK(iSCLK),
		.rst(rst),
		.sel(gpioSel),
		.adrs(adrs),
		.wd(wd),
		.we(we),
		.re(re),
		.gpioIn(gpioIn),
		.altIn(pwmOut),
		.rd(gpioRd),
		.gpioOut(gpioOut),
		.gpioDir(gpioDir)
	);

	pwmBlock pwm
	(
		.iSCLK(iSCLK),
		.rst(rst),
		.sel(pwmSel),
		.adrs(adrs),
		.wd(wd),
		.we(we),
		.re(re),
		.rd(pwmRd),
		.pwmOut(pwmOut)
	);

endmodule

`default_nettype wire

// ==== hw/pwmBlock.sv ====
// Multi channel PWM generator
`timescale 1ns/100ps
`default_nettype none

module pwmBlock
(
	input  logic iSCLK,
	input  logic rst,
	input  logic sel,
	input  usiBusPkg::usiData adrs,
	input  usiBusPkg::usiData wd,
	input  logic we,
	input  logic re,
	output usiBusPkg::usiData rd,
	output gpioPkg::gpioVec pwmOut
);

	typedef enum logic {stIdle, stRun} pwmState;

	usiBusPkg::csrAdrs csrOfs;
	logic wrEn;
	logic enable;
	gpioPkg::pwmCnt period;
	gpioPkg::pwmCnt duty [gpioPkg::gpioWidth];

	assign csrOfs = adrs[usiBusPkg::csrAdrsWidth-1:0];
	assign wrEn = sel & we;

	// Offset of a channel duty register
	function automatic usiBusPkg::csrAdrs dutyOfs(input int ch);
		return usiBusPkg::csrAdrs'(gpioPkg::pwmDutyBase + 4 * ch);
	endfunction

	// --------------------
	// CSR write
	// --------------------
	always_ff @(posedge iSCLK)
	begin
		if (rst)
		begin
			enable <= 1'b0;
			period <= '0;
			for (int i = 0; i < gpioPkg::gpioWidth; i++)
				duty[i] <= '0;
		end
		else if (wrEn)
		begin
			if (csrOfs == gpioPkg::pwmCtrlOfs)
				enable <= wd[0];
			if (csrOfs == gpioPkg::pwmPeriodOfs)
				period <= wd[gpioPkg::pwmWidth-1:0];
			for (int i = 0; i < gpioPkg::gpioWidth; i++)
				if (csrOfs == dutyOfs(i))
					duty[i] <= wd[gpioPkg::pwmWidth-1:0];
		end
	end

	// --------------------
	// CSR read
	// --------------------
	usiBusPkg::usiData rdMux;

	always_comb
	begin
		rdMux = '0;
		if (csrOfs == gpioPkg::pwmCtrlOfs)
			rdMux[0] = enable;
		if (csrOfs == gpioPkg::pwmPeriodOfs)
			rdMux[gpioPkg::pwmWidth-1:0] = period;
		for (int i = 0; i < gpioPkg::gpioWidth; i++)
			if (csrOfs == dutyOfs(i))
				rdMux[gpioPkg::pwmWidth-1:0] = duty[i];
	end

	always_ff @(posedge iSCLK)
	begin
		if (rst)
			rd <= '0;
		else
			rd <= (sel && re) ? rdMux : '0;
	end

	// --------------------
	// Counter and outputs
	// --------------------
	pwmState state;
	gpioPkg::pwmCnt cnt;
	gpioPkg::gpioVec outNext;

	// High while below the channel duty
	always_comb
	begin
		outNext = '0;
		for (int i = 0; i < gpioPkg::gpioWidth; i++)
			outNext[i] = (state == stRun) && enable && (cnt < duty[i]);
	end

	always_ff @(posedge iSCLK)
	begin
		if (rst)
		begin
			state <= stIdle;
			cnt <= '0;
			pwmOut <= '0;
		end
		else
		begin
			pwmOut <= outNext;
			case (state)
				stIdle:
				begin
					cnt <= '0;
					if (enable)
						state <= stRun;
				end
				stRun:
				begin
					// Stop clears the shared counter
					if (!enable)
					begin
						state <= stIdle;
						cnt <= '0;
					end
					// Wrap also covers a period lowered mid count
					else if (cnt >= period)
						cnt <= '0;
					else
						cnt <= cnt + 1'b1;
				end
				default: state <= stIdle;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hw/gpioBlock.sv ====
// GPIO block with output pin mux
`timescale 1ns/100ps
`default_nettype none

module gpioBlock
(
	input  logic iSCLK,
	input  logic rst,
	input  logic sel,
	input  usiBusPkg::usiData adrs,
	input  usiBusPkg::usiData wd,
	input  logic we,
	input  logic re,
	input  gpioPkg::gpioVec gpioIn,
	input  gpioPkg::gpioVec altIn,
	output usiBusPkg::usiData rd,
	output gpioPkg::gpioVec gpioOut,
	output gpioPkg::gpioVec gpioDir
);

	// --------------------
	// CSR space
	// --------------------
	gpioPkg::gpioVec outCtrl;
	gpioPkg::gpioVec altMode;

	gpioCsr csr
	(
		.iSCLK(iSCLK),
		.rst(rst),
		.sel(sel),
		.adrs(adrs),
		.wd(wd),
		.we(we),
		.re(re),
		.gpioIn(gpioIn),
		.rd(rd),
		.outCtrl(outCtrl),
		.dir(gpioDir),
		.altMode(altMode)
	);

	// --------------------
	// Pin mux
	// --------------------
	// Per pin, alternate source when its alt bit is set
	always_ff @(posedge iSCLK)
	begin
		if (rst)
			gpioOut <= '0;
		else
			gpioOut <= (altMode & altIn) | (~altMode & outCtrl);
	end

endmodule

`default_nettype wire

// ==== hw/gpioCsr.sv ====
// GPIO control and status registers
`timescale 1ns/100ps
`default_nettype none

module gpioCsr
(
	input  logic iSCLK,
	input  logic rst,
	input  logic sel,
	input  usiBusPkg::usiData adrs,
	input  usiBusPkg::usiData wd,
	input  logic we,
	input  logic re,
	input  gpioPkg::gpioVec gpioIn,
	output usiBusPkg::usiData rd,
	output gpioPkg::gpioVec outCtrl,
	output gpioPkg::gpioVec dir,
	output gpioPkg::gpioVec altMode
);

	usiBusPkg::csrAdrs csrOfs;
	logic wrEn;

	// Offset inside the block
	assign csrOfs = adrs[usiBusPkg::csrAdrsWidth-1:0];
	assign wrEn = sel & we;

	// --------------------
	// Write side
	// --------------------
	always_ff @(posedge iSCLK)
	begin
		if (rst)
		begin
			outCtrl <= '0;
			dir <= '0;
			altMode <= '0;
		end
		else if (wrEn)
		begin
			// Input offset is read only, write ignored
			case (csrOfs)
				gpioPkg::gpioOutOfs: outCtrl <= wd[gpioPkg::gpioWidth-1:0];
				gpioPkg::gpioDirOfs: dir <= wd[gpioPkg::gpioWidth-1:0];
				gpioPkg::gpioAltOfs: altMode <= wd[gpioPkg::gpioWidth-1:0];
				default: ;
			endcase
		end
	end

	// --------------------
	// Input sync
	// --------------------
	// Two flop synchronizer on the pins
	gpioPkg::gpioVec syncA;
	gpioPkg::gpioVec syncB;

	always_ff @(posedge iSCLK)
	begin
		if (rst)
		begin
			syncA <= '0;
			syncB <= '0;
		end
		else
		begin
			syncA <= gpioIn;
			syncB <= syncA;
		end
	end

	// --------------------
	// Read side
	// --------------------
	usiBusPkg::usiData rdMux;

	// Pin words zero extended to the bus width
	always_comb
	begin
		rdMux = '0;
		case (csrOfs)
			gpioPkg::gpioOutOfs: rdMux[gpioPkg::gpioWidth-1:0] = outCtrl;
			gpioPkg::gpioDirOfs: rdMux[gpioPkg::gpioWidth-1:0] = dir;
			gpioPkg::gpioAltOfs: rdMux[gpioPkg::gpioWidth-1:0] = altMode;
			gpioPkg::gpioInOfs: rdMux[gpioPkg::gpioWidth-1:0] = syncB;
			default: ;
		endcase
	end

	// One cycle after the request, zero when not addressed
	always_ff @(posedge iSCLK)
	begin
		if (rst)
			rd <= '0;
		else if (sel && re)
			rd <= rdMux;
		else
			rd <= '0;
	end

endmodule

`default_nettype wire

// ==== hw/usiBusHub.sv ====
// Bus block decode and read merge
`timescale 1ns/100ps
`default_nettype none

module usiBusHub
(
	input  logic iSCLK,
	input  logic rst,
	input  usiBusPkg::usiData adrs,
	input  logic re,
	input  usiBusPkg::usiData gpioRd,
	input  usiBusPkg::usiData pwmRd,
	output logic gpioSel,
	output logic pwmSel,
	output usiBusPkg::usiData rd
);

	// --------------------
	// Block decode
	// --------------------
	usiBusPkg::blockAdrs blockField;

	// Block number sits just above the CSR offset
	assign blockField = adrs[usiBusPkg::csrAdrsWidth +: usiBusPkg::blockAdrsWidth];
	assign gpioSel = (blockField == usiBusPkg::gpioBlockId);
	assign pwmSel = (blockField == usiBusPkg::pwmBlockId);

	// --------------------
	// Read return
	// --------------------
	// Request and select, one cycle behind, aligned with block read data
	logic rdPend;
	logic gpioSelQ;
	logic pwmSelQ;
	usiBusPkg::usiData rdMerge;

	// Unmapped block leaves both selects low, so the word is zero
	assign rdMerge = (gpioSelQ ? gpioRd : '0) | (pwmSelQ ? pwmRd : '0);

	always_ff @(posedge iSCLK)
	begin
		if (rst)
		begin
			rdPend <= 1'b0;
			gpioSelQ <= 1'b0;
			pwmSelQ <= 1'b0;
			rd <= '0;
		end
		else
		begin
			rdPend <= re;
			gpioSelQ <= gpioSel;
			pwmSelQ <= pwmSel;
			// Hold the last read word between reads
			if (rdPend)
				rd <= rdMerge;
		end
	end

endmodule

`default_nettype wire

// ==== hw/gpioPkg.sv ====
// GPIO and PWM definitions
`default_nettype none

package gpioPkg;

	// --------------------
	// Pins
	// --------------------
	// One bit per GPIO pin
	localparam int gpioWidth = 16;
	typedef logic [gpioWidth-1:0] gpioVec;

	// GPIO CSR offsets, word aligned
	localparam usiBusPkg::csrAdrs gpioOutOfs = 8'h00;
	localparam usiBusPkg::csrAdrs gpioDirOfs = 8'h04;
	localparam usiBusPkg::csrAdrs gpioAltOfs = 8'h08;
	// Read only, synchronized pin state
	localparam usiBusPkg::csrAdrs gpioInOfs = 8'h0c;

	// --------------------
	// PWM
	// --------------------
	// Period and duty counter width
	localparam int pwmWidth = 8;
	typedef logic [pwmWidth-1:0] pwmCnt;

	localparam usiBusPkg::csrAdrs pwmCtrlOfs = 8'h00;
	localparam usiBusPkg::csrAdrs pwmPeriodOfs = 8'h04;
	// Channel n sits at base plus 4 * n
	localparam usiBusPkg::csrAdrs pwmDutyBase = 8'h10;

endpackage

`default_nettype wire

// ==== hw/usiBusPkg.sv ====
// Register bus definitions
`default_nettype none

package usiBusPkg;

	// --------------------
	// Bus words
	// --------------------
	// Data and address word width
	localparam int busWidth = 32;
	typedef logic [busWidth-1:0] usiData;

	// --------------------
	// Address fields
	// --------------------
	// Block select, address bits 15..8
	localparam int blockAdrsWidth = 8;
	typedef logic [blockAdrsWidth-1:0] blockAdrs;

	// CSR offset inside a block, bits 7..0
	localparam int csrAdrsWidth = 8;
	typedef logic [csrAdrsWidth-1:0] csrAdrs;

	// --------------------
	// Block map
	// --------------------
	localparam blockAdrs gpioBlockId = 8'h01;
	localparam blockAdrs pwmBlockId = 8'h02;

endpackage

`default_nettype wire
